/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := csr_file_tb
FILELIST  := csr_file.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bench/csr_file_properties.sv */
`timescale 1ns/10ps

module csr_file_properties (
  input                             CLK,
  input                             nRST,
  input priv_types_pkg::csr_req_t   req,
  input priv_types_pkg::csr_rsp_t   rsp,
  input csr_map_pkg::csr_state_t    state
);

  // Idle bus carries no response
  idle_rsp_zero: assert property (@(posedge CLK) disable iff (!nRST)
    !req.valid |-> rsp == '0)
    else $error("rsp is not zero while req.valid is low");

  mpp_legal: assert property (@(posedge CLK) disable iff (!nRST)
    state.mstatus.mpp == priv_types_pkg::U_MODE || state.mstatus.mpp == priv_types_pkg::M_MODE)
    else $error("mstatus.mpp holds an unsupported mode");

  mtvec_mode_legal: assert property (@(posedge CLK) disable iff (!nRST)
    state.mtvec.mode == csr_map_pkg::DIRECT || state.mtvec.mode == csr_map_pkg::VECTORED)
    else $error("mtvec.mode holds a reserved value");

  refused_keeps_state: assert property (@(posedge CLK) disable iff (!nRST)
    req.valid && rsp.invalid |=> $stable(state))
    else $error("state changed after a refused request");

endmodule

bind csr_file csr_file_properties i_csr_file_properties (
  .CLK   (CLK),
  .nRST  (nRST),
  .req   (req),
  .rsp   (rsp),
  .state (state)
);

/* bench/csr_file_tb.sv */
`timescale 1ns/10ps

`include "csr_cfg.svh"

module csr_file_tb;

  localparam int CLK_PERIOD = 40;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // Feedback taps

  logic CLK;
  logic nRST;
  logic inst_ret;
  priv_types_pkg::csr_req_t    req;
  priv_types_pkg::priv_level_t priv;
  priv_types_pkg::csr_rsp_t    rsp;
  csr_map_pkg::csr_state_t     state;

  logic [31:0] lfsr_q = 32'd2;
  int checks = 0;
  int errors = 0;
  int test_base = 0;  // Error count at the start of the current test

  csr_file i_csr_file (
    .CLK      (CLK),
    .nRST     (nRST),
    .req      (req),
    .priv     (priv),
    .inst_ret (inst_ret),
    .rsp      (rsp),
    .state    (state)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Galois LFSR, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ LFSR_TAPS;
    end
    return out;
  endfunction

  function automatic priv_types_pkg::csr_word_t lfsr_word();
    priv_types_pkg::csr_word_t w;
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  task automatic check_word(input string name, input priv_types_pkg::csr_word_t got,
                            input priv_types_pkg::csr_word_t exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One strobe, starting just after a rising edge
  task automatic csr_access(input priv_types_pkg::csr_op_t op,
                            input priv_types_pkg::csr_addr_t addr,
                            input priv_types_pkg::csr_word_t wdata,
                            input logic exp_invalid,
                            output priv_types_pkg::csr_word_t rdata);
    req.valid = 1'b1;
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    @(negedge CLK);  // Response settled by mid-cycle
    checks++;
    assert (rsp.invalid == exp_invalid) else begin
      errors++;
      $display("Error at %0t: rsp.invalid = %b, expected %b (addr %h)",
               $time, rsp.invalid, exp_invalid, addr);
    end
    rdata = rsp.rdata;
    @(posedge CLK);
    #2;
    req = '0;
  endtask

  task automatic csr_read(input priv_types_pkg::csr_addr_t addr,
                          output priv_types_pkg::csr_word_t data);
    csr_access(priv_types_pkg::CSR_READ, addr, '0, 1'b0, data);
  endtask

  task automatic csr_write(input priv_types_pkg::csr_addr_t addr,
                           input priv_types_pkg::csr_word_t value);
    priv_types_pkg::csr_word_t unused;
    csr_access(priv_types_pkg::CSR_WRITE, addr, value, 1'b0, unused);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #2;
    end
  endtask

  task automatic report_test(input string name);
    $display("%-14s done, %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  task automatic test_reset_values();
    priv_types_pkg::csr_word_t d;
    csr_read(csr_map_pkg::MSTATUS_ADDR, d);
    check_word("mstatus", d, 32'h0020_0000);  // Only tw
    csr_read(csr_map_pkg::MCOUNTEREN_ADDR, d);
    check_word("mcounteren", d, 32'hFFFF_FFFF);
    csr_read(csr_map_pkg::MISA_ADDR, d);
    check_word("misa", d, 32'h4010_0100);  // MXL 1, I and U
    csr_read(csr_map_pkg::MHARTID_ADDR, d);
    check_word("mhartid", d, `CSR_HART_ID);
    csr_read(csr_map_pkg::MSCRATCH_ADDR, d);
    check_word("mscratch", d, 32'h0);
    report_test("reset_values");
  endtask

  task automatic test_read_modify_write();
    priv_types_pkg::csr_addr_t addrs [3];
    priv_types_pkg::csr_word_t model;
    priv_types_pkg::csr_word_t d;
    priv_types_pkg::csr_word_t w;
    addrs = '{csr_map_pkg::MSCRATCH_ADDR, csr_map_pkg::MEPC_ADDR, csr_map_pkg::MTVAL_ADDR};
    foreach (addrs[i]) begin
      model = '0;  // Untouched since reset
      w = lfsr_word();
      csr_access(priv_types_pkg::CSR_WRITE, addrs[i], w, 1'b0, d);
      check_word($sformatf("rsp.rdata[%h]", addrs[i]), d, model);
      model = w;
      w = lfsr_word();
      csr_access(priv_types_pkg::CSR_SET, addrs[i], w, 1'b0, d);
      check_word($sformatf("rsp.rdata[%h]", addrs[i]), d, model);
      model = model | w;
      w = lfsr_word();
      csr_access(priv_types_pkg::CSR_CLEAR, addrs[i], w, 1'b0, d);
      check_word($sformatf("rsp.rdata[%h]", addrs[i]), d, model);
      model = model & ~w;
      csr_read(addrs[i], d);
      check_word($sformatf("readback[%h]", addrs[i]), d, model);
      if (addrs[i] == csr_map_pkg::MEPC_ADDR) begin
        check_word("state.mepc", state.mepc, model);
      end
    end
    report_test("read_mod_write");
  endtask

  task automatic test_warl();
    priv_types_pkg::csr_word_t w;
    priv_types_pkg::csr_word_t d;
    priv_types_pkg::csr_word_t want;
    for (int m = 0; m < 4; m++) begin
      w = lfsr_word();
      w[12:11] = m[1:0];
      csr_write(csr_map_pkg::MSTATUS_ADDR, w);
      csr_read(csr_map_pkg::MSTATUS_ADDR, d);
      // mie, mpie, mprv and tw pass, mpp only as M
      want = (w & 32'h0022_0088) | ((m == 3) ? 32'h0000_1800 : 32'h0);
      check_word("mstatus", d, want);
      check_word("state.mstatus", state.mstatus, want);
    end
    for (int m = 0; m < 4; m++) begin
      w = lfsr_word();
      w[1:0] = m[1:0];
      csr_write(csr_map_pkg::MTVEC_ADDR, w);
      csr_read(csr_map_pkg::MTVEC_ADDR, d);
      want = (m == 1) ? w : {w[31:2], 2'b00};
      check_word("mtvec", d, want);
      check_word("state.mtvec", state.mtvec, want);
    end
    csr_write(csr_map_pkg::MIE_ADDR, 32'hFFFF_FFFF);
    csr_read(csr_map_pkg::MIE_ADDR, d);
    check_word("mie", d, 32'h0000_0888);
    check_word("state.mie", state.mie, 32'h0000_0888);
    w = lfsr_word();
    csr_write(csr_map_pkg::MIP_ADDR, w);
    csr_read(csr_map_pkg::MIP_ADDR, d);
    want = w & 32'h0000_0888;
    check_word("mip", d, want);
    check_word("state.mip", state.mip, want);
    report_test("warl");
  endtask

  task automatic test_access_faults();
    priv_types_pkg::csr_word_t w;
    priv_types_pkg::csr_word_t d;
    w = lfsr_word();
    csr_write(csr_map_pkg::MSCRATCH_ADDR, w);
    csr_read(csr_map_pkg::MSTATUS_ADDR, d);
    priv = priv_types_pkg::U_MODE;
    csr_access(priv_types_pkg::CSR_READ, csr_map_pkg::MSCRATCH_ADDR, '0, 1'b1, d);
    csr_access(priv_types_pkg::CSR_WRITE, csr_map_pkg::MSCRATCH_ADDR, ~w, 1'b1, d);
    // Refused write to a register that shows up in state
    csr_access(priv_types_pkg::CSR_WRITE, csr_map_pkg::MSTATUS_ADDR, ~d, 1'b1, d);
    priv = priv_types_pkg::M_MODE;
    csr_read(csr_map_pkg::MSCRATCH_ADDR, d);
    check_word("mscratch", d, w);
    // Read-only region
    csr_access(priv_types_pkg::CSR_WRITE, csr_map_pkg::MVENDORID_ADDR, lfsr_word(), 1'b1, d);
    csr_access(priv_types_pkg::CSR_SET, csr_map_pkg::MVENDORID_ADDR, 32'h1, 1'b1, d);
    csr_access(priv_types_pkg::CSR_READ, csr_map_pkg::MVENDORID_ADDR, '0, 1'b0, d);
    csr_access(priv_types_pkg::CSR_READ, 12'h7C0, '0, 1'b1, d);  // Unused address
    report_test("access_faults");
  endtask

  task automatic test_counters();
    priv_types_pkg::csr_word_t first;
    priv_types_pkg::csr_word_t m0;
    priv_types_pkg::csr_word_t d;
    priv_types_pkg::csr_word_t w;
    priv_types_pkg::csr_word_t pulses;
    csr_read(csr_map_pkg::MCYCLE_ADDR, first);
    repeat (6) begin
      csr_read(csr_map_pkg::MCYCLE_ADDR, d);
    end
    check_word("mcycle delta", d - first, 32'd6);
    csr_read(csr_map_pkg::MINSTRET_ADDR, m0);
    pulses = '0;
    for (int i = 0; i < 16; i++) begin
      inst_ret = lfsr_bit();
      if (inst_ret) begin
        pulses = pulses + 32'd1;
      end
      idle_cycles(1);
    end
    inst_ret = 1'b0;
    csr_read(csr_map_pkg::MINSTRET_ADDR, d);
    check_word("minstret delta", d - m0, pulses);
    csr_write(csr_map_pkg::MCOUNTINHIBIT_ADDR, 32'h5);  // cy and ir
    csr_read(csr_map_pkg::MCYCLE_ADDR, first);
    csr_read(csr_map_pkg::MINSTRET_ADDR, m0);
    inst_ret = 1'b1;
    idle_cycles(4);
    inst_ret = 1'b0;
    csr_read(csr_map_pkg::MCYCLE_ADDR, d);
    check_word("mcycle frozen", d, first);
    csr_read(csr_map_pkg::MINSTRET_ADDR, d);
    check_word("minstret frozen", d, m0);
    csr_write(csr_map_pkg::MCOUNTINHIBIT_ADDR, 32'h0);
    w = lfsr_word();
    csr_write(csr_map_pkg::MCYCLE_ADDR, w);
    csr_read(csr_map_pkg::MCYCLE_ADDR, d);
    check_word("mcycle", d, w);
    report_test("counters");
  endtask

  task automatic test_user_gating();
    priv_types_pkg::csr_word_t d;
    priv = priv_types_pkg::U_MODE;
    csr_access(priv_types_pkg::CSR_READ, csr_map_pkg::CYCLE_ADDR, '0, 1'b0, d);
    priv = priv_types_pkg::M_MODE;
    csr_access(priv_types_pkg::CSR_CLEAR, csr_map_pkg::MCOUNTEREN_ADDR, 32'h1, 1'b0, d);
    check_word("mcounteren", d, 32'hFFFF_FFFF);
    priv = priv_types_pkg::U_MODE;
    csr_access(priv_types_pkg::CSR_READ, csr_map_pkg::CYCLE_ADDR, '0, 1'b1, d);
    csr_access(priv_types_pkg::CSR_READ, csr_map_pkg::INSTRET_ADDR, '0, 1'b0, d);
    priv = priv_types_pkg::M_MODE;
    csr_write(csr_map_pkg::MCOUNTEREN_ADDR, 32'hFFFF_FFFF);
    report_test("user_gating");
  endtask

  // Guard against a stalled run
  initial begin
    #(CLK_PERIOD * 5000);
    $display("Timeout: the tests did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    nRST     = 1'b0;
    req      = '0;
    priv     = priv_types_pkg::M_MODE;
    inst_ret = 1'b0;
    repeat (5) @(posedge CLK);
    #2;
    nRST = 1'b1;
    test_reset_values();
    test_read_modify_write();
    test_warl();
    test_access_faults();
    test_counters();
    test_user_gating();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* csr_file.f */
+incdir+hw
hw/priv_types_pkg.sv
hw/csr_map_pkg.sv
hw/csr_access_check.sv
hw/csr_machine_regs.sv
hw/csr_counters.sv
hw/csr_file.sv
bench/csr_file_properties.sv
bench/csr_file_tb.sv

/* hw/csr_access_check.sv */
`timescale 1ns/10ps

module csr_access_check (
  input  priv_types_pkg::csr_req_t    req,
  input  priv_types_pkg::priv_level_t priv,
  input  priv_types_pkg::csr_rd_t     mach_rd,
  input  priv_types_pkg::csr_rd_t     cnt_rd,
  output priv_types_pkg::csr_wr_t     wr,
  output priv_types_pkg::csr_rsp_t    rsp
);

  priv_types_pkg::csr_word_t old_val;
  priv_types_pkg::csr_word_t new_val;
  logic hit;
  logic deny;
  logic is_read;
  logic ro_fault;
  logic priv_fault;
  logic invalid;

  // Old value from whichever bank owns the address
  always_comb begin
    hit  = mach_rd.hit | cnt_rd.hit;
    deny = 1'b0;
    old_val = '0;
    if (mach_rd.hit) begin
      old_val = mach_rd.data;
      deny    = mach_rd.deny;
    end else if (cnt_rd.hit) begin
      old_val = cnt_rd.data;
      deny    = cnt_rd.deny;
    end
  end

  // Read-modify-write value
  always_comb begin
    case (req.op)
      priv_types_pkg::CSR_WRITE: new_val = req.wdata;
      priv_types_pkg::CSR_SET:   new_val = old_val | req.wdata;
      priv_types_pkg::CSR_CLEAR: new_val = old_val & ~req.wdata;
      default:                   new_val = old_val;  // Plain read
    endcase
  end

  assign is_read = (req.op == priv_types_pkg::CSR_READ);

  // Top quarter of the address space is read only
  assign ro_fault = (req.addr[11:10] == 2'b11) && !is_read;

  // Bits 9:8 encode the lowest privilege allowed
  assign priv_fault = (req.addr[9:8] > priv);

  assign invalid = ro_fault | priv_fault | !hit | deny;

  always_comb begin
    wr.en    = req.valid && !invalid && !is_read;
    wr.addr  = req.addr;
    wr.value = new_val;
  end

  // Response only while the strobe is up
  always_comb begin
    rsp = '0;
    if (req.valid) begin
      rsp.invalid = invalid;
      // Refused requests leak no data
      rsp.rdata   = invalid ? '0 : old_val;
    end
  end

endmodule

/* hw/csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Data word width, RV32 only
`define CSR_XLEN 32

// CSR address space
`define CSR_ADDR_W 12

// Value returned by mhartid
`define CSR_HART_ID 0

// misa extension field, I (bit 8) and U (bit 20)
`define CSR_MISA_EXT 26'h0100100

`endif

/* hw/csr_counters.sv */
`timescale 1ns/10ps

`include "csr_cfg.svh"

module csr_counters (
  input                               CLK,
  input                               nRST,
  input  priv_types_pkg::csr_wr_t     wr,
  input  priv_types_pkg::csr_addr_t   addr,
  input  priv_types_pkg::priv_level_t priv,
  input                               inst_ret,
  input  csr_map_pkg::cnt_ctl_t       cnt_ctl,
  output priv_types_pkg::csr_rd_t     rd
);

  logic [2*`CSR_XLEN-1:0] cycle_q;
  logic [2*`CSR_XLEN-1:0] cycle_d;
  logic [2*`CSR_XLEN-1:0] instret_q;
  logic [2*`CSR_XLEN-1:0] instret_d;
  logic                   user_mode;

  assign user_mode = (priv == priv_types_pkg::U_MODE);

  always_comb begin
    cycle_d   = cycle_q;
    instret_d = instret_q;
    if (!cnt_ctl.mcountinhibit.cy) begin
      cycle_d = cycle_q + 1'b1;
    end
    if (inst_ret && !cnt_ctl.mcountinhibit.ir) begin
      instret_d = instret_q + 1'b1;
    end
    // A write replaces one half and wins over the increment
    if (wr.en) begin
      case (wr.addr)
        csr_map_pkg::MCYCLE_ADDR:    cycle_d   = {cycle_q[63:32], wr.value};
        csr_map_pkg::MCYCLEH_ADDR:   cycle_d   = {wr.value, cycle_q[31:0]};
        csr_map_pkg::MINSTRET_ADDR:  instret_d = {instret_q[63:32], wr.value};
        csr_map_pkg::MINSTRETH_ADDR: instret_d = {wr.value, instret_q[31:0]};
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycle_q   <= '0;
      instret_q <= '0;
    end else begin
      cycle_q   <= cycle_d;
      instret_q <= instret_d;
    end
  end

  // Address bit 7 selects the high half
  always_comb begin
    rd = '0;
    case (addr)
      csr_map_pkg::MCYCLE_ADDR, csr_map_pkg::MCYCLEH_ADDR: begin
        rd.hit  = 1'b1;
        rd.data = addr[7] ? cycle_q[63:32] : cycle_q[31:0];
      end
      csr_map_pkg::MINSTRET_ADDR, csr_map_pkg::MINSTRETH_ADDR: begin
        rd.hit  = 1'b1;
        rd.data = addr[7] ? instret_q[63:32] : instret_q[31:0];
      end
      csr_map_pkg::CYCLE_ADDR, csr_map_pkg::CYCLEH_ADDR: begin
        rd.hit  = 1'b1;
        rd.deny = user_mode && !cnt_ctl.mcounteren.cy;  // User alias gated by mcounteren
        rd.data = addr[7] ? cycle_q[63:32] : cycle_q[31:0];
      end
      csr_map_pkg::INSTRET_ADDR, csr_map_pkg::INSTRETH_ADDR: begin
        rd.hit  = 1'b1;
        rd.deny = user_mode && !cnt_ctl.mcounteren.ir;
        rd.data = addr[7] ? instret_q[63:32] : instret_q[31:0];
      end
      default: ;
    endcase
  end

endmodule

/* hw/csr_file.sv */
`timescale 1ns/10ps

module csr_file (
  input                               CLK,
  input                               nRST,
  input  priv_types_pkg::csr_req_t    req,
  input  priv_types_pkg::priv_level_t priv,
  input                               inst_ret,
  output priv_types_pkg::csr_rsp_t    rsp,
  output csr_map_pkg::csr_state_t     state
);

  priv_types_pkg::csr_wr_t wr;       // Legal write, both banks
  priv_types_pkg::csr_rd_t mach_rd;
  priv_types_pkg::csr_rd_t cnt_rd;
  csr_map_pkg::cnt_ctl_t   cnt_ctl;

  csr_access_check i_csr_access_check (
    .req     (req),
    .priv    (priv),
    .mach_rd (mach_rd),
    .cnt_rd  (cnt_rd),
    .wr      (wr),
    .rsp     (rsp)
  );

  csr_machine_regs i_csr_machine_regs (
    .CLK     (CLK),
    .nRST    (nRST),
    .wr      (wr),
    .addr    (req.addr),
    .rd      (mach_rd),
    .cnt_ctl (cnt_ctl),
    .state   (state)
  );

  csr_counters i_csr_counters (
    .CLK      (CLK),
    .nRST     (nRST),
    .wr       (wr),
    .addr     (req.addr),
    .priv     (priv),
    .inst_ret (inst_ret),
    .cnt_ctl  (cnt_ctl),
    .rd       (cnt_rd)
  );

endmodule

/* hw/csr_machine_regs.sv */
`timescale 1ns/10ps

`include "csr_cfg.svh"

module csr_machine_regs (
  input                               CLK,
  input                               nRST,
  input  priv_types_pkg::csr_wr_t     wr,
  input  priv_types_pkg::csr_addr_t   addr,
  output priv_types_pkg::csr_rd_t     rd,
  output csr_map_pkg::cnt_ctl_t       cnt_ctl,
  output csr_map_pkg::csr_state_t     state
);

  csr_map_pkg::mstatus_t      mstatus;
  csr_map_pkg::mtvec_t        mtvec;
  csr_map_pkg::irq_bits_t     mie;
  csr_map_pkg::irq_bits_t     mip;
  csr_map_pkg::counter_bits_t mcounteren;
  csr_map_pkg::counter_bits_t mcountinhibit;
  priv_types_pkg::csr_word_t  mscratch;
  priv_types_pkg::csr_word_t  mepc;
  priv_types_pkg::csr_word_t  mcause;
  priv_types_pkg::csr_word_t  mtval;

  // Legalized forms of the written word
  csr_map_pkg::mstatus_t  mstatus_wr;
  csr_map_pkg::mtvec_t    mtvec_wr;
  csr_map_pkg::irq_bits_t irq_wr;
  priv_types_pkg::csr_word_t misa;

  always_comb begin
    mstatus_wr      = '0;
    mstatus_wr.mie  = wr.value[3];
    mstatus_wr.mpie = wr.value[7];
    mstatus_wr.mprv = wr.value[17];
    mstatus_wr.tw   = wr.value[21];
    // No S-mode, so only M survives
    mstatus_wr.mpp  = (wr.value[12:11] == 2'b11) ? priv_types_pkg::M_MODE
                                                  : priv_types_pkg::U_MODE;

    mtvec_wr.base = wr.value[31:2];
    mtvec_wr.mode = (wr.value[1:0] > 2'd1) ? csr_map_pkg::DIRECT
                                           : csr_map_pkg::vec_mode_t'(wr.value[1:0]);

    irq_wr          = '0;
    irq_wr.software = wr.value[3];
    irq_wr.timer    = wr.value[7];
    irq_wr.external = wr.value[11];
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus       <= csr_map_pkg::mstatus_t'(32'h0020_0000);  // tw set, mpp = U
      mtvec         <= '0;
      mie           <= '0;
      mip           <= '0;
      mcounteren    <= '1;
      mcountinhibit <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
    end else if (wr.en) begin
      case (wr.addr)
        csr_map_pkg::MSTATUS_ADDR:       mstatus       <= mstatus_wr;
        csr_map_pkg::MTVEC_ADDR:         mtvec         <= mtvec_wr;
        csr_map_pkg::MIE_ADDR:           mie           <= irq_wr;
        csr_map_pkg::MIP_ADDR:           mip           <= irq_wr;
        csr_map_pkg::MCOUNTEREN_ADDR:    mcounteren    <= wr.value;
        csr_map_pkg::MCOUNTINHIBIT_ADDR: mcountinhibit <= wr.value;
        csr_map_pkg::MSCRATCH_ADDR:      mscratch      <= wr.value;
        csr_map_pkg::MEPC_ADDR:          mepc          <= wr.value;
        csr_map_pkg::MCAUSE_ADDR:        mcause        <= wr.value;
        csr_map_pkg::MTVAL_ADDR:         mtval         <= wr.value;
        default: ;  // Not ours, or constant
      endcase
    end
  end

  // MXL = 1 for RV32
  assign misa = {2'b01, 4'b0000, `CSR_MISA_EXT};

  always_comb begin
    rd      = '0;
    rd.hit  = 1'b1;
    rd.deny = 1'b0;
    case (addr)
      csr_map_pkg::MSTATUS_ADDR:       rd.data = mstatus;
      csr_map_pkg::MISA_ADDR:          rd.data = misa;
      csr_map_pkg::MTVEC_ADDR:         rd.data = mtvec;
      csr_map_pkg::MIE_ADDR:           rd.data = mie;
      csr_map_pkg::MIP_ADDR:           rd.data = mip;
      csr_map_pkg::MCOUNTEREN_ADDR:    rd.data = mcounteren;
      csr_map_pkg::MCOUNTINHIBIT_ADDR: rd.data = mcountinhibit;
      csr_map_pkg::MSCRATCH_ADDR:      rd.data = mscratch;
      csr_map_pkg::MEPC_ADDR:          rd.data = mepc;
      csr_map_pkg::MCAUSE_ADDR:        rd.data = mcause;
      csr_map_pkg::MTVAL_ADDR:         rd.data = mtval;
      csr_map_pkg::MHARTID_ADDR:       rd.data = priv_types_pkg::csr_word_t'(`CSR_HART_ID);
      csr_map_pkg::MSTATUSH_ADDR,
      csr_map_pkg::MVENDORID_ADDR,
      csr_map_pkg::MARCHID_ADDR,
      csr_map_pkg::MIMPID_ADDR,
      csr_map_pkg::MCONFIGPTR_ADDR:    rd.data = '0;
      default:                         rd.hit  = 1'b0;
    endcase
  end

  assign cnt_ctl.mcounteren    = mcounteren;
  assign cnt_ctl.mcountinhibit = mcountinhibit;

  always_comb begin
    state.mstatus = mstatus;
    state.mtvec   = mtvec;
    state.mepc    = mepc;
    state.mie     = mie;
    state.mip     = mip;
  end

endmodule

/* hw/csr_map_pkg.sv */
package csr_map_pkg;

  // Machine trap setup
  localparam priv_types_pkg::csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam priv_types_pkg::csr_addr_t MISA_ADDR          = 12'h301;
  localparam priv_types_pkg::csr_addr_t MIE_ADDR           = 12'h304;
  localparam priv_types_pkg::csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam priv_types_pkg::csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam priv_types_pkg::csr_addr_t MSTATUSH_ADDR      = 12'h310;
  localparam priv_types_pkg::csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  // Machine trap handling
  localparam priv_types_pkg::csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam priv_types_pkg::csr_addr_t MEPC_ADDR          = 12'h341;
  localparam priv_types_pkg::csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam priv_types_pkg::csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam priv_types_pkg::csr_addr_t MIP_ADDR           = 12'h344;
  // Counters, high halves at +0x80
  localparam priv_types_pkg::csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam priv_types_pkg::csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam priv_types_pkg::csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam priv_types_pkg::csr_addr_t MINSTRETH_ADDR     = 12'hB82;
  localparam priv_types_pkg::csr_addr_t CYCLE_ADDR         = 12'hC00;
  localparam priv_types_pkg::csr_addr_t INSTRET_ADDR       = 12'hC02;
  localparam priv_types_pkg::csr_addr_t CYCLEH_ADDR        = 12'hC80;
  localparam priv_types_pkg::csr_addr_t INSTRETH_ADDR      = 12'hC82;
  // Machine information, read only
  localparam priv_types_pkg::csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam priv_types_pkg::csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam priv_types_pkg::csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam priv_types_pkg::csr_addr_t MHARTID_ADDR       = 12'hF14;
  localparam priv_types_pkg::csr_addr_t MCONFIGPTR_ADDR    = 12'hF15;

  typedef struct packed {
    logic [9:0]                  reserved_5;
    logic                        tw;          // Timeout wait
    logic [2:0]                  reserved_4;
    logic                        mprv;
    logic [3:0]                  reserved_3;
    priv_types_pkg::priv_level_t mpp;
    logic [2:0]                  reserved_2;
    logic                        mpie;
    logic [2:0]                  reserved_1;
    logic                        mie;
    logic [2:0]                  reserved_0;
  } mstatus_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } vec_mode_t;

  typedef struct packed {
    logic [29:0] base;
    vec_mode_t   mode;
  } mtvec_t;

  // Shared by mie and mip, machine bits only
  typedef struct packed {
    logic [19:0] reserved_3;
    logic        external;
    logic [2:0]  reserved_2;
    logic        timer;
    logic [2:0]  reserved_1;
    logic        software;
    logic [2:0]  reserved_0;
  } irq_bits_t;

  typedef struct packed {
    logic [28:0] reserved;
    logic        ir;
    logic        tm;
    logic        cy;
  } counter_bits_t;

  // Counter control from the machine bank to the counter bank
  typedef struct packed {
    counter_bits_t mcounteren;
    counter_bits_t mcountinhibit;
  } cnt_ctl_t;

  // Current trap state for the logic outside the file
  typedef struct packed {
    mstatus_t                  mstatus;
    mtvec_t                    mtvec;
    priv_types_pkg::csr_word_t mepc;
    irq_bits_t                 mie;
    irq_bits_t                 mip;
  } csr_state_t;

endpackage

/* hw/priv_types_pkg.sv */
`include "csr_cfg.svh"

package priv_types_pkg;

  typedef logic [`CSR_XLEN-1:0]   csr_word_t;
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    CSR_READ  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_t;

  // One-cycle request from the host
  typedef struct packed {
    logic      valid;
    csr_op_t   op;
    csr_addr_t addr;
    csr_word_t wdata;
  } csr_req_t;

  typedef struct packed {
    logic      invalid;
    csr_word_t rdata;   // Old value of the CSR
  } csr_rsp_t;

  // Legalized write from the check stage to the banks
  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    csr_word_t value;
  } csr_wr_t;

  typedef struct packed {
    logic      hit;
    logic      deny;
    csr_word_t data;
  } csr_rd_t;

endpackage
